// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := ooo_core_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/alu.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module alu import ooo_pkg::*; (
  input  logic  clk_100mhz,
  input  logic  sys_rst,
  input  exec_t i_exec,
  output cdb_t  o_cdb
);

  logic [`OOO_XLEN-1:0] a;
  logic [`OOO_XLEN-1:0] b;
  logic [`OOO_XLEN-1:0] result;
  logic [4:0]           shamt;

  assign a     = i_exec.val1;
  assign b     = i_exec.val2;
  assign shamt = b[4:0]; // only low 5 bits shift

  always_comb begin
    case (i_exec.op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(`OOO_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: result = {{(`OOO_XLEN-1){1'b0}}, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

  // one cycle from dispatch to broadcast
  always_ff @(posedge clk_100mhz) begin
    o_cdb.tag   <= i_exec.tag;
    o_cdb.value <= result;
    if (sys_rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= i_exec.valid;
    end
  end

endmodule

// File: hw/issue_stage.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module issue_stage import ooo_pkg::*; (
  input  logic                 clk_100mhz,
  input  logic                 sys_rst,
  input  logic                 i_inst_valid,
  input  logic [31:0]          i_inst,
  input  rf_read_t             i_rs1,
  input  rf_read_t             i_rs2,
  input  logic [`OOO_XLEN-1:0] i_rob_val1,
  input  logic [`OOO_XLEN-1:0] i_rob_val2,
  input  logic                 i_rob_done1,
  input  logic                 i_rob_done2,
  input  rob_tag_t             i_tail_tag,
  input  logic                 i_rob_full,
  input  logic                 i_rs_full,
  output logic [4:0]           o_rs1_addr,
  output logic [4:0]           o_rs2_addr,
  output rob_tag_t             o_rob_tag1,
  output rob_tag_t             o_rob_tag2,
  output logic                 o_inst_ready,
  output issue_t               o_issue
);

  opcode_e    opc;
  logic [2:0] funct3;
  logic       alt_bit; // picks SUB / SRA

  // register file first, then a finished rob entry, else wait on the tag
  function automatic operand_t pick_src(rf_read_t rf, logic [`OOO_XLEN-1:0] rob_val,
                                        logic rob_done);
    operand_t src;
    src.tag = rf.tag;
    if (!rf.busy) begin
      src.value = rf.value;
      src.ready = 1'b1;
    end else if (rob_done) begin
      src.value = rob_val;
      src.ready = 1'b1;
    end else begin
      src.value = '0;
      src.ready = 1'b0;
    end
    return src;
  endfunction

  assign funct3 = i_inst[14:12];
  assign o_rs1_addr = i_inst[19:15];
  assign o_rs2_addr = i_inst[24:20];
  assign o_rob_tag1 = i_rs1.tag; // look up the producer in the rob
  assign o_rob_tag2 = i_rs2.tag;
  assign o_inst_ready = !i_rob_full && !i_rs_full;

  always_comb begin
    case (i_inst[6:0])
      OPC_OP:     opc = OPC_OP;
      OPC_OP_IMM: opc = OPC_OP_IMM;
      default:    opc = OPC_OTHER;
    endcase
  end

  // ADDI has no subtract form, only SRAI uses bit 30 on the immediate side
  always_comb begin
    if (opc == OPC_OP) begin
      alt_bit = i_inst[30] && (funct3 == 3'b000 || funct3 == 3'b101);
    end else begin
      alt_bit = i_inst[30] && (funct3 == 3'b101);
    end
  end

  always_comb begin
    o_issue.valid = i_inst_valid && o_inst_ready && (opc != OPC_OTHER);
    o_issue.op    = alu_op_e'({alt_bit, funct3});
    o_issue.src1  = pick_src(i_rs1, i_rob_val1, i_rob_done1);
    if (opc == OPC_OP_IMM) begin
      o_issue.src2.value = {{(`OOO_XLEN-12){i_inst[31]}}, i_inst[31:20]};
      o_issue.src2.ready = 1'b1;
      o_issue.src2.tag   = '0;
    end else begin
      o_issue.src2 = pick_src(i_rs2, i_rob_val2, i_rob_done2);
    end
    o_issue.rd  = i_inst[11:7];
    o_issue.tag = i_tail_tag;
  end

  a_no_issue_when_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_issue.valid |-> !i_rob_full && !i_rs_full);

endmodule

// File: hw/ooo_core.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module ooo_core import ooo_pkg::*; (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  output logic        o_inst_ready,
  output commit_t     o_commit
);

  logic [4:0]           rs1_addr, rs2_addr;
  rf_read_t             rs1_rd, rs2_rd;
  rob_tag_t             rob_tag1, rob_tag2;
  logic [`OOO_XLEN-1:0] rob_val1, rob_val2;
  logic                 rob_done1, rob_done2;
  rob_tag_t             tail_tag;
  logic                 rob_full, rs_full;
  issue_t               issue;
  exec_t                exec;
  cdb_t                 cdb;

  issue_stage issue_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .i_rs1(rs1_rd), .i_rs2(rs2_rd),
    .i_rob_val1(rob_val1), .i_rob_val2(rob_val2),
    .i_rob_done1(rob_done1), .i_rob_done2(rob_done2),
    .i_tail_tag(tail_tag), .i_rob_full(rob_full), .i_rs_full(rs_full),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
    .o_rob_tag1(rob_tag1), .o_rob_tag2(rob_tag2),
    .o_inst_ready(o_inst_ready), .o_issue(issue)
  );

  register_file regfile_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .i_issue(issue), .i_commit(o_commit),
    .o_rs1(rs1_rd), .o_rs2(rs2_rd)
  );

  reorder_buffer rob_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue(issue), .i_cdb(cdb), .i_tag1(rob_tag1), .i_tag2(rob_tag2),
    .o_val1(rob_val1), .o_val2(rob_val2), .o_done1(rob_done1), .o_done2(rob_done2),
    .o_tail_tag(tail_tag), .o_full(rob_full), .o_commit(o_commit)
  );

  reservation_station rs_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue(issue), .i_cdb(cdb),
    .o_full(rs_full), .o_exec(exec)
  );

  alu alu_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_exec(exec), .o_cdb(cdb)
  );

endmodule

// File: hw/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath width
`define OOO_XLEN 32

// architectural registers x0..x31
`define OOO_NUM_REGS 32

// reorder buffer entries, must stay a power of two
`define OOO_ROB_SIZE 8

// reservation station entries
`define OOO_RS_DEPTH 4

// log2 of OOO_ROB_SIZE
`define OOO_TAG_W 3

`endif

// File: hw/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

  // {funct7[5], funct3} of the RV32I integer ops
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OTHER  = 7'b0000000 // anything else, dropped at issue
  } opcode_e;

  typedef logic [`OOO_TAG_W-1:0] rob_tag_t;

  // tag is only meaningful while ready is low
  typedef struct packed {
    logic [`OOO_XLEN-1:0] value;
    logic                 ready;
    rob_tag_t             tag;
  } operand_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    operand_t src1;
    operand_t src2;
    logic [4:0] rd;
    rob_tag_t tag;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    alu_op_e              op;
    logic [`OOO_XLEN-1:0] val1;
    logic [`OOO_XLEN-1:0] val2;
    rob_tag_t             tag;
  } exec_t;

  typedef struct packed {
    logic                 valid;
    rob_tag_t             tag;
    logic [`OOO_XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic                 valid;
    rob_tag_t             tag;
    logic [4:0]           rd;
    logic [`OOO_XLEN-1:0] value;
  } commit_t;

  typedef struct packed {
    logic [`OOO_XLEN-1:0] value;
    logic                 busy;
    rob_tag_t             tag;
  } rf_read_t;

endpackage

// File: hw/register_file.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module register_file import ooo_pkg::*; (
  input  logic       clk_100mhz,
  input  logic       sys_rst,
  input  logic [4:0] i_rs1_addr,
  input  logic [4:0] i_rs2_addr,
  input  issue_t     i_issue,
  input  commit_t    i_commit,
  output rf_read_t   o_rs1,
  output rf_read_t   o_rs2
);

  logic [`OOO_XLEN-1:0]     regs_q [`OOO_NUM_REGS];
  logic [`OOO_NUM_REGS-1:0] busy_q;
  rob_tag_t                 tags_q [`OOO_NUM_REGS];

  function automatic rf_read_t read_port(logic [4:0] addr);
    rf_read_t rd_val;
    if (addr == 5'd0) begin
      rd_val = '0; // x0 is hardwired
    end else begin
      rd_val.value = regs_q[addr];
      rd_val.busy  = busy_q[addr];
      rd_val.tag   = tags_q[addr];
    end
    return rd_val;
  endfunction

  assign o_rs1 = read_port(i_rs1_addr);
  assign o_rs2 = read_port(i_rs2_addr);

  always_ff @(posedge clk_100mhz) begin
    // rename tag, valid only while busy
    if (i_issue.valid && i_issue.rd != 5'd0) begin
      tags_q[i_issue.rd] <= i_issue.tag;
    end

    if (sys_rst) begin
      busy_q <= '0;
      for (int r = 0; r < `OOO_NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      if (i_commit.valid && i_commit.rd != 5'd0) begin
        regs_q[i_commit.rd] <= i_commit.value;
        // a younger rename keeps the register busy
        if (tags_q[i_commit.rd] == i_commit.tag) begin
          busy_q[i_commit.rd] <= 1'b0;
        end
      end
      // issue after commit so a same-cycle rename wins
      if (i_issue.valid && i_issue.rd != 5'd0) begin
        busy_q[i_issue.rd] <= 1'b1;
      end
    end
  end

endmodule

// File: hw/reorder_buffer.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module reorder_buffer import ooo_pkg::*; (
  input  logic                 clk_100mhz,
  input  logic                 sys_rst,
  input  issue_t               i_issue,
  input  cdb_t                 i_cdb,
  input  rob_tag_t             i_tag1,
  input  rob_tag_t             i_tag2,
  output logic [`OOO_XLEN-1:0] o_val1,
  output logic [`OOO_XLEN-1:0] o_val2,
  output logic                 o_done1,
  output logic                 o_done2,
  output rob_tag_t             o_tail_tag,
  output logic                 o_full,
  output commit_t              o_commit
);

  localparam int CNT_W = `OOO_TAG_W + 1;

  rob_tag_t                 head_q;
  rob_tag_t                 tail_q;
  logic [CNT_W-1:0]         count_q;
  logic [4:0]               rd_q   [`OOO_ROB_SIZE];
  logic [`OOO_XLEN-1:0]     val_q  [`OOO_ROB_SIZE];
  logic [`OOO_ROB_SIZE-1:0] done_q;

  logic     alloc;
  logic     retire;
  rob_tag_t cdb_dist; // distance of the bus tag from head
  logic     cdb_live;

  assign alloc  = i_issue.valid;
  assign retire = o_commit.valid;

  assign o_full     = (count_q == CNT_W'(`OOO_ROB_SIZE));
  assign o_tail_tag = tail_q;

  // operand lookups for busy registers
  assign o_val1  = val_q[i_tag1];
  assign o_val2  = val_q[i_tag2];
  assign o_done1 = done_q[i_tag1];
  assign o_done2 = done_q[i_tag2];

  // head retires the cycle after it went done
  always_comb begin
    o_commit.valid = (count_q != '0) && done_q[head_q];
    o_commit.tag   = head_q;
    o_commit.rd    = rd_q[head_q];
    o_commit.value = val_q[head_q];
  end

  assign cdb_dist = i_cdb.tag - head_q;
  assign cdb_live = (CNT_W'(cdb_dist) < count_q);

  always_ff @(posedge clk_100mhz) begin
    if (alloc) begin
      rd_q[tail_q] <= i_issue.rd;
    end
    if (i_cdb.valid) begin
      val_q[i_cdb.tag] <= i_cdb.value;
    end

    if (sys_rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc) begin
        tail_q         <= tail_q + 1'b1;
        done_q[tail_q] <= 1'b0; // fresh entry
      end
      if (i_cdb.valid) begin
        done_q[i_cdb.tag] <= 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(alloc) - CNT_W'(retire);
    end
  end

  a_no_overflow: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    count_q <= CNT_W'(`OOO_ROB_SIZE));

  // a result must land on a live entry exactly once
  a_cdb_tag_live: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_cdb.valid |-> cdb_live && !done_q[i_cdb.tag]);

endmodule

// File: hw/reservation_station.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module reservation_station import ooo_pkg::*; (
  input  logic   clk_100mhz,
  input  logic   sys_rst,
  input  issue_t i_issue,
  input  cdb_t   i_cdb,
  output logic   o_full,
  output exec_t  o_exec
);

  localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

  logic [`OOO_RS_DEPTH-1:0] busy_q;
  alu_op_e                  op_q   [`OOO_RS_DEPTH];
  operand_t                 src1_q [`OOO_RS_DEPTH];
  operand_t                 src2_q [`OOO_RS_DEPTH];
  rob_tag_t                 tag_q  [`OOO_RS_DEPTH];

  logic [`OOO_RS_DEPTH-1:0] ready_vec;
  logic [IDX_W-1:0]         free_idx;
  logic [IDX_W-1:0]         disp_idx;

  // capture a broadcast result if this operand is waiting on it
  function automatic operand_t snoop(operand_t src, cdb_t cdb);
    operand_t res;
    res = src;
    if (cdb.valid && !src.ready && src.tag == cdb.tag) begin
      res.value = cdb.value;
      res.ready = 1'b1;
    end
    return res;
  endfunction

  assign o_full = &busy_q;

  always_comb begin
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      ready_vec[i] = busy_q[i] && src1_q[i].ready && src2_q[i].ready;
    end
  end

  // scan downwards so the lowest index wins
  always_comb begin
    free_idx = '0;
    disp_idx = '0;
    for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy_q[i]) free_idx = IDX_W'(i);
      if (ready_vec[i]) disp_idx = IDX_W'(i);
    end
  end

  always_comb begin
    o_exec.valid = |ready_vec; // alu never stalls
    o_exec.op    = op_q[disp_idx];
    o_exec.val1  = src1_q[disp_idx].value;
    o_exec.val2  = src2_q[disp_idx].value;
    o_exec.tag   = tag_q[disp_idx];
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      src1_q[i] <= snoop(src1_q[i], i_cdb);
      src2_q[i] <= snoop(src2_q[i], i_cdb);
    end
    if (i_issue.valid) begin
      op_q[free_idx]   <= i_issue.op;
      src1_q[free_idx] <= snoop(i_issue.src1, i_cdb); // result may arrive this cycle
      src2_q[free_idx] <= snoop(i_issue.src2, i_cdb);
      tag_q[free_idx]  <= i_issue.tag;
    end

    if (sys_rst) begin
      busy_q <= '0;
    end else begin
      if (o_exec.valid) begin
        busy_q[disp_idx] <= 1'b0;
      end
      if (i_issue.valid) begin
        busy_q[free_idx] <= 1'b1;
      end
    end
  end

  a_no_insert_when_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_issue.valid |-> !o_full);

endmodule

// File: tb.f
+incdir+hw
hw/ooo_pkg.sv
hw/issue_stage.sv
hw/register_file.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/alu.sv
hw/ooo_core.sv
verif/ooo_core_tb.sv

// File: verif/ooo_core_tb.sv
`timescale 1ns/100ps
`include "ooo_defines.svh"

module ooo_core_tb import ooo_pkg::*; ();

  localparam int XLEN      = `OOO_XLEN;
  localparam int N_RANDOM  = 2000;
  localparam int N_CHAIN   = 300;
  localparam int N_DISCARD = 300;
  localparam int WATCHDOG_CYCLES = (N_RANDOM + N_CHAIN + N_DISCARD) * 20 + 1000;

  typedef logic [XLEN-1:0] word_t;

  logic        clk_100mhz = 1'b0;
  logic        sys_rst;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic        o_inst_ready;
  commit_t     o_commit;

  word_t   model_regs [`OOO_NUM_REGS]; // architectural state in program order
  commit_t expected_q [$];
  int      n_accepted = 0;  // OP and OP-IMM only
  int      n_discarded = 0;
  int      n_committed = 0;
  int      errors = 0;
  int      occ_errors = 0;
  int      tests_run = 0;
  int      tests_failed = 0;
  int      test_err_base = 0;
  string   cur_test = "none";

  ooo_core dut_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_inst_ready(o_inst_ready), .o_commit(o_commit)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  task automatic compare_rd(string name, logic [4:0] exp, logic [4:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] rd: expected x%0d, actual x%0d", name, exp, act);
    end
  endtask

  task automatic compare_tag(string name, rob_tag_t exp, rob_tag_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] tag: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_value(string name, word_t exp, word_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] value: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic compare_commit(string name, commit_t exp, commit_t act);
    compare_tag(name, exp.tag, act.tag);
    compare_rd(name, exp.rd, act.rd);
    compare_value(name, exp.value, act.value);
  endtask

  task automatic compare_flag(string name, string what, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] %s: expected %b, actual %b", name, what, exp, act);
    end
  endtask

  task automatic compare_count(string name, string what, int exp, int act);
    if (act != exp) begin
      errors++;
      $display("** Error [%s] %s: expected %0d, actual %0d", name, what, exp, act);
    end
  endtask

  // RV32I semantics straight from the ISA rules
  function automatic word_t model_result(logic [31:0] w);
    word_t      a;
    word_t      b;
    logic [2:0] f3;
    logic       alt;
    a  = model_regs[w[19:15]];
    f3 = w[14:12];
    if (w[6:0] == OPC_OP_IMM) begin
      b   = {{(XLEN-12){w[31]}}, w[31:20]};
      alt = w[30] && (f3 == 3'b101); // only SRAI
    end else begin
      b   = model_regs[w[24:20]];
      alt = w[30];
    end
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      3'b011:  return (a < b) ? word_t'(1) : '0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // legal encodings with bit 30 set just for SUB/SRA/SRAI
  function automatic logic [31:0] alu_word(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                                           bit imm_form);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'($urandom_range(7, 0));
    alt = 1'($urandom_range(1, 0));
    imm = 12'($urandom);
    if (imm_form) begin
      if (f3 == 3'b001) imm[11:5] = 7'b0000000;
      if (f3 == 3'b101) imm[11:5] = {1'b0, alt, 5'b00000};
      return {imm, rs1, f3, rd, OPC_OP_IMM};
    end
    if (f3 != 3'b000 && f3 != 3'b101) alt = 1'b0;
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  // mode 0 is the random pool, 1 the x3 chain and 2 mostly other opcodes
  function automatic logic [31:0] pick_word(int mode);
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          other_pct;
    other_pct = (mode == 2) ? 50 : ((mode == 1) ? 0 : 10);
    if ($urandom_range(99, 0) < other_pct) begin
      w = $urandom;
      while (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
        w[6:0] = 7'($urandom);
      end
      return w;
    end
    if (mode == 1) begin
      rd  = 5'd3;
      rs1 = 5'd3;
      rs2 = 5'd3;
    end else begin
      rd  = 5'($urandom_range(5, 0)); // small pool for frequent hazards
      rs1 = 5'($urandom_range(5, 0));
      rs2 = 5'($urandom_range(5, 0));
    end
    return alu_word(rd, rs1, rs2, $urandom_range(1, 0) == 1);
  endfunction

  task automatic run_words(int n, int valid_pct, int mode);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk_100mhz);
      if (i_inst_valid && o_inst_ready) sent++;
      if (sent < n && $urandom_range(99, 0) < valid_pct) begin
        i_inst_valid <= 1'b1;
        i_inst       <= pick_word(mode);
      end else begin
        i_inst_valid <= 1'b0;
      end
    end
  endtask

  task automatic drain(int settle);
    @(negedge clk_100mhz);
    while (expected_q.size() != 0) @(negedge clk_100mhz);
    repeat (settle) @(negedge clk_100mhz);
  endtask

  task automatic begin_test(string name);
    cur_test      = name;
    test_err_base = errors;
  endtask

  task automatic end_test(int n_err);
    tests_run++;
    if (n_err > 0) tests_failed++;
    $display("%-16s %s (%0d errors)", cur_test, (n_err > 0) ? "FAIL" : "PASS", n_err);
  endtask

  // in-order model and commit scoreboard
  always @(posedge clk_100mhz) begin
    commit_t exp_c;
    if (!sys_rst) begin
      if (o_commit.valid) begin
        n_committed++;
        if (expected_q.size() == 0) begin
          errors++;
          $display("[%s] the core committed x%0d but no accepted instruction was waiting",
                   cur_test, o_commit.rd);
        end else begin
          exp_c = expected_q.pop_front();
          compare_commit(cur_test, exp_c, o_commit);
        end
      end
      if (i_inst_valid && o_inst_ready) begin
        if (i_inst[6:0] == OPC_OP || i_inst[6:0] == OPC_OP_IMM) begin
          exp_c.valid = 1'b1;
          exp_c.tag   = rob_tag_t'(n_accepted % `OOO_ROB_SIZE);
          exp_c.rd    = i_inst[11:7];
          exp_c.value = model_result(i_inst);
          if (exp_c.rd != 5'd0) model_regs[exp_c.rd] = exp_c.value;
          expected_q.push_back(exp_c);
          n_accepted++;
        end else begin
          n_discarded++;
        end
      end
      if (n_accepted - n_committed > `OOO_ROB_SIZE) begin
        occ_errors++;
        $display("[occupancy] %0d instructions in flight, more than the %0d buffer entries",
                 n_accepted - n_committed, `OOO_ROB_SIZE);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
    $display("timeout: the core did not drain its instructions within %0d cycles",
             WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int base_acc;
    int base_com;
    int base_disc;
    void'($urandom(44));
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    for (int r = 0; r < `OOO_NUM_REGS; r++) model_regs[r] = '0;

    begin_test("reset_state");
    for (int c = 0; c < 16; c++) begin
      @(posedge clk_100mhz);
      if (c == 15) sys_rst <= 1'b0;
      @(negedge clk_100mhz); // last pass is the first cycle out of reset
      compare_flag(cur_test, "commit valid", 1'b0, o_commit.valid);
      compare_flag(cur_test, "inst ready", 1'b1, o_inst_ready);
    end
    end_test(errors - test_err_base);

    begin_test("random_results");
    run_words(N_RANDOM, 70, 0);
    drain(5);
    compare_count(cur_test, "commits", n_accepted, n_committed);
    end_test(errors - test_err_base);

    begin_test("forwarding");
    base_acc = n_accepted;
    base_com = n_committed;
    run_words(N_CHAIN / 2, 100, 1); // back to back on x3
    run_words(N_CHAIN - N_CHAIN / 2, 40, 1); // gaps let x3 come from the buffer or the file
    drain(5);
    compare_count(cur_test, "commits", n_accepted - base_acc, n_committed - base_com);
    end_test(errors - test_err_base);

    begin_test("discarded_words");
    base_acc  = n_accepted;
    base_com  = n_committed;
    base_disc = n_discarded;
    run_words(N_DISCARD, 80, 2);
    drain(20);
    compare_count(cur_test, "commits", n_accepted - base_acc, n_committed - base_com);
    if (n_discarded == base_disc) begin
      errors++;
      $display("[%s] no word with another opcode was accepted", cur_test);
    end
    end_test(errors - test_err_base);

    cur_test = "occupancy";
    end_test(occ_errors);

    $display("tests %0d, failed %0d, errors %0d, occupancy errors %0d, commits %0d, dropped %0d",
             tests_run, tests_failed, errors, occ_errors, n_committed, n_discarded);
    if (tests_failed == 0 && errors == 0 && occ_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
